/* common/dma_settings.svh */
// Port count, address, length, id and register widths of the DMA subsystem
`ifndef DMA_SETTINGS_SVH
`define DMA_SETTINGS_SVH

// Number of configuration ports
`define DMA_NUM_PORTS 2

// Address, length and id widths
`define DMA_ADDR_W 64
`define DMA_LEN_W 32
`define DMA_ID_W 32

// Register word address and data widths
`define DMA_REG_AW 4
`define DMA_REG_DW 32

`endif

/* common/dma_reg_pkg.sv */
// Register map address enum and CONF bit positions
`include "dma_settings.svh"

package dma_reg_pkg;

  // Word addresses of one configuration port
  typedef enum logic [`DMA_REG_AW-1:0] {
    SRC_LO     = 4'd0,
    SRC_HI     = 4'd1,
    DST_LO     = 4'd2,
    DST_HI     = 4'd3,
    LENGTH     = 4'd4,
    CONF       = 4'd5,
    SRC_STRIDE = 4'd6,
    DST_STRIDE = 4'd7,
    REPS       = 4'd8,
    // Reading this one launches a transfer
    NEXT_ID    = 4'd9,
    DONE_ID    = 4'd10,
    STATUS     = 4'd11
  } dma_reg_addr_e;

  // CONF bit that turns on the second dimension
  localparam int unsigned CONF_ENABLE_ND = 0;

endpackage

/* common/dma_req_pkg.sv */
// 2D job and 1D burst structs and the midend state enum
`include "dma_settings.svh"

package dma_req_pkg;

  // 2D job as handed from the front-end to the midend
  typedef struct packed {
    logic [`DMA_ADDR_W-1:0] src_addr;
    logic [`DMA_ADDR_W-1:0] dst_addr;
    logic [`DMA_LEN_W-1:0]  length;
    logic [`DMA_LEN_W-1:0]  src_stride;
    logic [`DMA_LEN_W-1:0]  dst_stride;
    // Zero means a single burst
    logic [`DMA_LEN_W-1:0]  reps;
  } dma_job_t;

  // One 1D burst towards the backend
  typedef struct packed {
    logic [`DMA_ADDR_W-1:0] src_addr;
    logic [`DMA_ADDR_W-1:0] dst_addr;
    logic [`DMA_LEN_W-1:0]  length;
  } dma_burst_t;

  // Midend FSM states
  typedef enum logic {
    IDLE  = 1'b0,
    ISSUE = 1'b1
  } dma_mid_state_e;

endpackage

/* frontend/dma_reg_file.sv */
// Configuration register file of one port with launch on NEXT_ID read
`include "dma_settings.svh"

module dma_reg_file (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        reg_valid_i,
  input  logic                        reg_write_i,
  input  logic [`DMA_REG_AW-1:0]      reg_addr_i,
  input  logic [`DMA_REG_DW-1:0]      reg_wdata_i,
  output logic [`DMA_REG_DW-1:0]      reg_rdata_o,
  output logic                        reg_ready_o,
  output logic                        job_req_o,
  output dma_req_pkg::dma_job_t       job_o,
  input  logic                        job_gnt_i,
  input  logic [`DMA_ID_W-1:0]        next_id_i,
  input  logic [`DMA_ID_W-1:0]        done_id_i,
  input  logic [1:0]                  status_i
);

  dma_reg_pkg::dma_reg_addr_e addr;

  logic [`DMA_REG_DW-1:0] src_lo_q, src_hi_q, dst_lo_q, dst_hi_q;
  logic [`DMA_REG_DW-1:0] length_q, src_stride_q, dst_stride_q, reps_q;
  logic                   enable_nd_q;
  logic                   launch_read;

  assign addr = dma_reg_pkg::dma_reg_addr_e'(reg_addr_i);

  // A read of NEXT_ID asks for a job until the midend takes it
  assign launch_read = reg_valid_i && !reg_write_i && (addr == dma_reg_pkg::NEXT_ID);
  assign job_req_o   = launch_read;
  assign reg_ready_o = launch_read ? job_gnt_i : 1'b1;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      src_lo_q     <= '0;
      src_hi_q     <= '0;
      dst_lo_q     <= '0;
      dst_hi_q     <= '0;
      length_q     <= '0;
      enable_nd_q  <= 1'b0;
      src_stride_q <= '0;
      dst_stride_q <= '0;
      reps_q       <= '0;
    end else if (reg_valid_i && reg_write_i) begin
      // Read-only words fall through to the default
      case (addr)
        dma_reg_pkg::SRC_LO:     src_lo_q     <= reg_wdata_i;
        dma_reg_pkg::SRC_HI:     src_hi_q     <= reg_wdata_i;
        dma_reg_pkg::DST_LO:     dst_lo_q     <= reg_wdata_i;
        dma_reg_pkg::DST_HI:     dst_hi_q     <= reg_wdata_i;
        dma_reg_pkg::LENGTH:     length_q     <= reg_wdata_i;
        dma_reg_pkg::CONF:       enable_nd_q  <= reg_wdata_i[dma_reg_pkg::CONF_ENABLE_ND];
        dma_reg_pkg::SRC_STRIDE: src_stride_q <= reg_wdata_i;
        dma_reg_pkg::DST_STRIDE: dst_stride_q <= reg_wdata_i;
        dma_reg_pkg::REPS:       reps_q       <= reg_wdata_i;
        default: ;
      endcase
    end
  end

  // Read data mux
  always_comb begin
    reg_rdata_o = '0;
    case (addr)
      dma_reg_pkg::SRC_LO:     reg_rdata_o = src_lo_q;
      dma_reg_pkg::SRC_HI:     reg_rdata_o = src_hi_q;
      dma_reg_pkg::DST_LO:     reg_rdata_o = dst_lo_q;
      dma_reg_pkg::DST_HI:     reg_rdata_o = dst_hi_q;
      dma_reg_pkg::LENGTH:     reg_rdata_o = length_q;
      dma_reg_pkg::CONF:       reg_rdata_o[dma_reg_pkg::CONF_ENABLE_ND] = enable_nd_q;
      dma_reg_pkg::SRC_STRIDE: reg_rdata_o = src_stride_q;
      dma_reg_pkg::DST_STRIDE: reg_rdata_o = dst_stride_q;
      dma_reg_pkg::REPS:       reg_rdata_o = reps_q;
      dma_reg_pkg::NEXT_ID:    reg_rdata_o = next_id_i;
      dma_reg_pkg::DONE_ID:    reg_rdata_o = done_id_i;
      dma_reg_pkg::STATUS:     reg_rdata_o[1:0] = status_i;
      default: ;
    endcase
  end

  // Job assembly from the programmed words
  always_comb begin
    job_o            = '0;
    job_o.src_addr   = {src_hi_q, src_lo_q};
    job_o.dst_addr   = {dst_hi_q, dst_lo_q};
    job_o.length     = length_q;
    job_o.src_stride = src_stride_q;
    job_o.dst_stride = dst_stride_q;
    // 1D transfer unless the second dimension is on
    job_o.reps       = enable_nd_q ? reps_q : '0;
  end

endmodule

/* frontend/dma_rr_arb.sv */
// Round-robin job arbiter with lock-in under back-pressure
`include "dma_settings.svh"

module dma_rr_arb #(
  parameter int unsigned NUM_IN = `DMA_NUM_PORTS
) (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  input  logic                  [NUM_IN-1:0]  req_i,
  input  dma_req_pkg::dma_job_t [NUM_IN-1:0]  data_i,
  output logic                  [NUM_IN-1:0]  gnt_o,
  output logic                                valid_o,
  output dma_req_pkg::dma_job_t               data_o,
  input  logic                                ready_i
);

  localparam int unsigned IDX_W = (NUM_IN > 1) ? $clog2(NUM_IN) : 1;

  logic [IDX_W-1:0] ptr_q, lock_idx_q, rr_idx, sel;
  logic             locked_q, rr_found;

  // First requester at or after the priority pointer
  always_comb begin : proc_rr_pick
    int unsigned cand;
    rr_idx   = ptr_q;
    rr_found = 1'b0;
    for (int unsigned off = 0; off < NUM_IN; off++) begin
      cand = (ptr_q + off) % NUM_IN;
      if (!rr_found && req_i[cand]) begin
        rr_found = 1'b1;
        rr_idx   = IDX_W'(cand);
      end
    end
  end

  // Stalled choice stays put
  assign sel     = locked_q ? lock_idx_q : rr_idx;
  assign valid_o = req_i[sel];
  assign data_o  = data_i[sel];

  always_comb begin
    gnt_o      = '0;
    gnt_o[sel] = valid_o && ready_i;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ptr_q      <= '0;
      lock_idx_q <= '0;
      locked_q   <= 1'b0;
    end else begin
      locked_q   <= valid_o && !ready_i;
      lock_idx_q <= sel;
      // Move priority past the winner
      if (valid_o && ready_i) begin
        ptr_q <= (sel == IDX_W'(NUM_IN - 1)) ? '0 : sel + 1'b1;
      end
    end
  end

endmodule

/* frontend/dma_reg_frontend.sv */
// Per-port register files, job back-pressure and port arbitration
`include "dma_settings.svh"

module dma_reg_frontend (
  input  logic                                           clk_i,
  input  logic                                           rst_n_i,
  input  logic [`DMA_NUM_PORTS-1:0]                      reg_valid_i,
  input  logic [`DMA_NUM_PORTS-1:0]                      reg_write_i,
  input  logic [`DMA_NUM_PORTS-1:0][`DMA_REG_AW-1:0]     reg_addr_i,
  input  logic [`DMA_NUM_PORTS-1:0][`DMA_REG_DW-1:0]     reg_wdata_i,
  output logic [`DMA_NUM_PORTS-1:0][`DMA_REG_DW-1:0]     reg_rdata_o,
  output logic [`DMA_NUM_PORTS-1:0]                      reg_ready_o,
  output logic                                           job_valid_o,
  output dma_req_pkg::dma_job_t                          job_o,
  input  logic                                           job_ready_i,
  input  logic [`DMA_ID_W-1:0]                           next_id_i,
  input  logic [`DMA_ID_W-1:0]                           done_id_i,
  input  logic [1:0]                                     status_i
);

  // Per-port job requests and grants
  logic                  [`DMA_NUM_PORTS-1:0] port_req;
  logic                  [`DMA_NUM_PORTS-1:0] port_gnt;
  dma_req_pkg::dma_job_t [`DMA_NUM_PORTS-1:0] port_job;

  for (genvar p = 0; p < `DMA_NUM_PORTS; p++) begin : gen_ports
    // Grant doubles as the NEXT_ID read completion
    dma_reg_file dma_reg_file_i (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .reg_valid_i (reg_valid_i[p]),
      .reg_write_i (reg_write_i[p]),
      .reg_addr_i  (reg_addr_i[p]),
      .reg_wdata_i (reg_wdata_i[p]),
      .reg_rdata_o (reg_rdata_o[p]),
      .reg_ready_o (reg_ready_o[p]),
      .job_req_o   (port_req[p]),
      .job_o       (port_job[p]),
      .job_gnt_i   (port_gnt[p]),
      .next_id_i   (next_id_i),
      .done_id_i   (done_id_i),
      .status_i    (status_i)
    );
  end

  // Lock-in keeps the job stable until the midend takes it
  dma_rr_arb #(
    .NUM_IN (`DMA_NUM_PORTS)
  ) dma_rr_arb_i (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .req_i   (port_req),
    .data_i  (port_job),
    .gnt_o   (port_gnt),
    .valid_o (job_valid_o),
    .data_o  (job_o),
    .ready_i (job_ready_i)
  );

endmodule

/* midend/dma_2d_midend.sv */
// 2D to 1D burst splitter with id assignment and completion tracking
`include "dma_settings.svh"

module dma_2d_midend (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    job_valid_i,
  input  dma_req_pkg::dma_job_t   job_i,
  output logic                    job_ready_o,
  output logic                    burst_valid_o,
  output dma_req_pkg::dma_burst_t burst_o,
  input  logic                    burst_ready_i,
  input  logic                    burst_done_i,
  output logic [`DMA_ID_W-1:0]    next_id_o,
  output logic [`DMA_ID_W-1:0]    done_id_o,
  output logic [1:0]              status_o
);

  localparam int unsigned FIFO_DEPTH = 4;
  localparam int unsigned PTR_W      = $clog2(FIFO_DEPTH);
  localparam int unsigned PAD_W      = `DMA_ADDR_W - `DMA_LEN_W;

  dma_req_pkg::dma_mid_state_e state_q;

  // Current job, stepped per burst
  logic [`DMA_ADDR_W-1:0] src_q, dst_q;
  logic [`DMA_LEN_W-1:0]  len_q, src_stride_q, dst_stride_q, rem_q;
  logic [`DMA_ID_W-1:0]   cur_id_q, next_id_q, done_id_q;

  // Outstanding burst FIFO, entry is {last, id}
  logic [`DMA_ID_W:0]   fifo_mem [FIFO_DEPTH];
  logic [`DMA_ID_W:0]   pop_entry;
  logic [PTR_W-1:0]     wr_ptr_q, rd_ptr_q;
  logic [PTR_W:0]       count_q;
  logic                 fifo_full, accept, take, pop, last_burst;

  assign fifo_full   = (count_q == (PTR_W + 1)'(FIFO_DEPTH));
  assign job_ready_o = (state_q == dma_req_pkg::IDLE) && !fifo_full;
  assign accept      = job_valid_i && job_ready_o;

  // No burst without room to track its completion
  assign burst_valid_o    = (state_q == dma_req_pkg::ISSUE) && !fifo_full;
  assign burst_o.src_addr = src_q;
  assign burst_o.dst_addr = dst_q;
  assign burst_o.length   = len_q;

  assign take       = burst_valid_o && burst_ready_i;
  assign last_burst = (rem_q == `DMA_LEN_W'(1));
  assign pop        = burst_done_i && (count_q != '0);
  assign pop_entry  = fifo_mem[rd_ptr_q];

  assign next_id_o = next_id_q;
  assign done_id_o = done_id_q;
  assign status_o  = {count_q != '0, state_q != dma_req_pkg::IDLE};

  // Job payload
  always_ff @(posedge clk_i) begin
    if (accept) begin
      src_q        <= job_i.src_addr;
      dst_q        <= job_i.dst_addr;
      len_q        <= job_i.length;
      src_stride_q <= job_i.src_stride;
      dst_stride_q <= job_i.dst_stride;
      cur_id_q     <= next_id_q;
    end else if (take) begin
      src_q <= src_q + {{PAD_W{1'b0}}, src_stride_q};
      dst_q <= dst_q + {{PAD_W{1'b0}}, dst_stride_q};
    end
  end

  always_ff @(posedge clk_i) begin
    if (take) begin
      fifo_mem[wr_ptr_q] <= {last_burst, cur_id_q};
    end
  end

  // FSM, id counter and FIFO pointers
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q   <= dma_req_pkg::IDLE;
      rem_q     <= '0;
      next_id_q <= `DMA_ID_W'(1);
      done_id_q <= '0;
      wr_ptr_q  <= '0;
      rd_ptr_q  <= '0;
      count_q   <= '0;
    end else begin
      case (state_q)
        dma_req_pkg::IDLE: begin
          if (accept) begin
            // reps of zero still gives one burst
            rem_q     <= (job_i.reps == '0) ? `DMA_LEN_W'(1) : job_i.reps;
            next_id_q <= next_id_q + 1'b1;
            state_q   <= dma_req_pkg::ISSUE;
          end
        end
        dma_req_pkg::ISSUE: begin
          if (take) begin
            rem_q <= rem_q - 1'b1;
            if (last_burst) begin
              state_q <= dma_req_pkg::IDLE;
            end
          end
        end
        default: state_q <= dma_req_pkg::IDLE;
      endcase

      if (take) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
        if (pop_entry[`DMA_ID_W]) begin
          done_id_q <= pop_entry[`DMA_ID_W-1:0];
        end
      end
      case ({take, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: ;
      endcase
    end
  end

endmodule

/* hw/dma_2d_top.sv */
// Top level joining the register front-end and the 2D midend
`include "dma_settings.svh"

module dma_2d_top (
  input  logic                                        clk_i,
  input  logic                                        rst_n_i,
  input  logic [`DMA_NUM_PORTS-1:0]                   reg_valid_i,
  input  logic [`DMA_NUM_PORTS-1:0]                   reg_write_i,
  input  logic [`DMA_NUM_PORTS-1:0][`DMA_REG_AW-1:0]  reg_addr_i,
  input  logic [`DMA_NUM_PORTS-1:0][`DMA_REG_DW-1:0]  reg_wdata_i,
  output logic [`DMA_NUM_PORTS-1:0][`DMA_REG_DW-1:0]  reg_rdata_o,
  output logic [`DMA_NUM_PORTS-1:0]                   reg_ready_o,
  output logic                                        burst_valid_o,
  output dma_req_pkg::dma_burst_t                     burst_o,
  input  logic                                        burst_ready_i,
  input  logic                                        burst_done_i
);

  // Job handoff
  logic                  job_valid, job_ready;
  dma_req_pkg::dma_job_t job;

  // Status shared back to all ports
  logic [`DMA_ID_W-1:0] next_id, done_id;
  logic [1:0]           status;

  dma_reg_frontend dma_reg_frontend_i (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .reg_valid_i (reg_valid_i),
    .reg_write_i (reg_write_i),
    .reg_addr_i  (reg_addr_i),
    .reg_wdata_i (reg_wdata_i),
    .reg_rdata_o (reg_rdata_o),
    .reg_ready_o (reg_ready_o),
    .job_valid_o (job_valid),
    .job_o       (job),
    .job_ready_i (job_ready),
    .next_id_i   (next_id),
    .done_id_i   (done_id),
    .status_i    (status)
  );

  dma_2d_midend dma_2d_midend_i (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .job_valid_i   (job_valid),
    .job_i         (job),
    .job_ready_o   (job_ready),
    .burst_valid_o (burst_valid_o),
    .burst_o       (burst_o),
    .burst_ready_i (burst_ready_i),
    .burst_done_i  (burst_done_i),
    .next_id_o     (next_id),
    .done_id_o     (done_id),
    .status_o      (status)
  );

endmodule

/* test/dma_sva_chk.sv */
// Concurrent checks on the burst handshake, reset and completion pulses
module dma_sva_chk (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    burst_valid_i,
  input  dma_req_pkg::dma_burst_t burst_i,
  input  logic                    burst_ready_i,
  input  logic                    burst_done_i,
  input  logic                    outstanding_i
);
  timeunit 1ns;
  timeprecision 1ps;

  int unsigned fail_cnt = 0;

  // Burst held unchanged under back-pressure
  burst_hold_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    burst_valid_i && !burst_ready_i |=> burst_valid_i && $stable(burst_i))
  else begin
    fail_cnt++;
    $error("burst_o changed or dropped while stalled");
  end

  // Quiet output while reset is held
  reset_quiet_a : assert property (@(posedge clk_i)
    !rst_n_i && $past(!rst_n_i) |-> !burst_valid_i)
  else begin
    fail_cnt++;
    $error("burst_valid_o high during reset");
  end

  // Each done pulse needs a burst in flight
  done_tracked_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    burst_done_i |-> outstanding_i)
  else begin
    fail_cnt++;
    $error("done pulse with no outstanding burst");
  end

endmodule

/* test/dma_monitor.sv */
// Comparing monitor for register reads and bursts leaving the DUT
`include "dma_settings.svh"

module dma_monitor (
  input  logic                                        clk_i,
  input  logic                                        rst_n_i,
  input  logic [`DMA_NUM_PORTS-1:0]                   reg_valid_i,
  input  logic [`DMA_NUM_PORTS-1:0]                   reg_write_i,
  input  logic [`DMA_NUM_PORTS-1:0]                   reg_ready_i,
  input  logic [`DMA_NUM_PORTS-1:0][`DMA_REG_DW-1:0]  reg_rdata_i,
  input  logic [`DMA_NUM_PORTS-1:0]                   exp_rd_en_i,
  input  logic [`DMA_NUM_PORTS-1:0][`DMA_REG_DW-1:0]  exp_rd_data_i,
  input  logic                                        burst_valid_i,
  input  dma_req_pkg::dma_burst_t                     burst_i,
  input  logic                                        burst_ready_i,
  input  logic                                        exp_push_i,
  input  dma_req_pkg::dma_burst_t                     exp_burst_i,
  input  int                                          test_num_i,
  input  logic                                        test_end_i,
  output logic                                        exp_pending_o,
  output int                                          err_cnt_o,
  output int                                          chk_cnt_o
);
  timeunit 1ns;
  timeprecision 1ps;

  // Bursts still owed by the DUT, oldest first
  dma_req_pkg::dma_burst_t exp_q[$];
  dma_req_pkg::dma_burst_t exp_head;
  int   err_cnt  = 0;
  int   chk_cnt  = 0;
  int   test_err = 0;
  logic pending  = 1'b0;

  assign exp_pending_o = pending;
  assign err_cnt_o     = err_cnt;
  assign chk_cnt_o     = chk_cnt;

  always @(posedge clk_i) begin
    if (rst_n_i) begin
      // Reads complete on valid and ready
      for (int p = 0; p < `DMA_NUM_PORTS; p++) begin
        if (reg_valid_i[p] && !reg_write_i[p] && reg_ready_i[p] && exp_rd_en_i[p]) begin
          chk_cnt++;
          if (reg_rdata_i[p] !== exp_rd_data_i[p]) begin
            $display("MISMATCH reg_rdata_o[%0d]: got %h, expected %h",
                     p, reg_rdata_i[p], exp_rd_data_i[p]);
            err_cnt++;
            test_err++;
          end
        end
      end
      if (burst_valid_i && burst_ready_i) begin
        if (exp_q.size() == 0) begin
          $display("A burst left the DUT while none was expected");
          err_cnt++;
          test_err++;
        end else begin
          exp_head = exp_q.pop_front();
          chk_cnt++;
          if (burst_i !== exp_head) begin
            $display("MISMATCH burst_o: got %h, expected %h", burst_i, exp_head);
            err_cnt++;
            test_err++;
          end
        end
      end
      if (exp_push_i) begin
        exp_q.push_back(exp_burst_i);
      end
      if (test_end_i) begin
        $display("test %0d %s with %0d errors", test_num_i,
                 (test_err == 0) ? "passed" : "failed", test_err);
        test_err = 0;
      end
    end
    pending <= (exp_q.size() != 0);
  end

endmodule

/* test/dma_tb.sv */
// Testbench top with clock, reset, vector stimulus, backend model and watchdog
`include "dma_settings.svh"

module dma_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int          CLK_HALF  = 20;
  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

  logic                                        clk = 1'b0;
  logic                                        rst_n;
  logic [`DMA_NUM_PORTS-1:0]                   reg_valid, reg_write, reg_ready, exp_rd_en;
  logic [`DMA_NUM_PORTS-1:0][`DMA_REG_AW-1:0]  reg_addr;
  logic [`DMA_NUM_PORTS-1:0][`DMA_REG_DW-1:0]  reg_wdata, reg_rdata, exp_rd_data;
  logic                                        burst_valid;
  dma_req_pkg::dma_burst_t                     burst, exp_burst;
  logic        burst_ready = 1'b0;
  logic        burst_done  = 1'b0;
  logic        loaded      = 1'b0;
  logic        exp_push, exp_pending, test_end, hold_done;
  logic [31:0] lfsr_q      = 32'h25ec_c21c;
  int          taken_cnt   = 0;
  int          done_cnt    = 0;
  int          done_wait   = 0;
  int          tb_err      = 0;
  int          cur_test, err_cnt, chk_cnt, vec_cnt;

  // Parsed vector columns
  int          vec_test[$], vec_mask[$], vec_reg[$];
  logic [7:0]  vec_op[$];
  logic [63:0] vec_d0[$], vec_d1[$], vec_d2[$];

  always #CLK_HALF clk = ~clk;

  dma_2d_top dma_2d_top_i (
    .clk_i         (clk),
    .rst_n_i       (rst_n),
    .reg_valid_i   (reg_valid),
    .reg_write_i   (reg_write),
    .reg_addr_i    (reg_addr),
    .reg_wdata_i   (reg_wdata),
    .reg_rdata_o   (reg_rdata),
    .reg_ready_o   (reg_ready),
    .burst_valid_o (burst_valid),
    .burst_o       (burst),
    .burst_ready_i (burst_ready),
    .burst_done_i  (burst_done)
  );

  dma_monitor dma_monitor_i (
    .clk_i         (clk),
    .rst_n_i       (rst_n),
    .reg_valid_i   (reg_valid),
    .reg_write_i   (reg_write),
    .reg_ready_i   (reg_ready),
    .reg_rdata_i   (reg_rdata),
    .exp_rd_en_i   (exp_rd_en),
    .exp_rd_data_i (exp_rd_data),
    .burst_valid_i (burst_valid),
    .burst_i       (burst),
    .burst_ready_i (burst_ready),
    .exp_push_i    (exp_push),
    .exp_burst_i   (exp_burst),
    .test_num_i    (cur_test),
    .test_end_i    (test_end),
    .exp_pending_o (exp_pending),
    .err_cnt_o     (err_cnt),
    .chk_cnt_o     (chk_cnt)
  );

  bind dma_2d_midend dma_sva_chk dma_sva_chk_i (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .burst_valid_i (burst_valid_o),
    .burst_i       (burst_o),
    .burst_ready_i (burst_ready_i),
    .burst_done_i  (burst_done_i),
    .outstanding_i (status_o[1])
  );

  // Galois LFSR, one step per bit drawn
  function automatic int draw_bits(input int n);
    int v;
    v = 0;
    for (int k = 0; k < n; k++) begin
      v = {v[30:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ LFSR_TAPS) : (lfsr_q >> 1);
    end
    return v;
  endfunction

  always @(posedge clk) begin
    if (rst_n && burst_valid && burst_ready) begin
      taken_cnt++;
    end
  end

  // Backend model with random stalls and in-order done pulses
  always @(negedge clk) begin
    burst_done = 1'b0;
    if (!rst_n) begin
      burst_ready = 1'b0;
    end else begin
      burst_ready = (draw_bits(2) != 0);
      if (!hold_done && taken_cnt != done_cnt) begin
        if (done_wait == 0) begin
          burst_done = 1'b1;
          done_cnt++;
          done_wait = draw_bits(3);
        end else begin
          done_wait--;
        end
      end
    end
  end

  task automatic load_vectors();
    int          fd, n, t, m, a;
    logic [7:0]  op;
    logic [63:0] x0, x1, x2;
    string       line;
    fd = $fopen("test/dma_vectors.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the vector file test/dma_vectors.txt");
      tb_err++;
    end else begin
      while ($fgets(line, fd) != 0) begin
        n = $sscanf(line, "%d %s %h %h %h %h %h", t, op, m, a, x0, x1, x2);
        // Comment and blank lines do not parse
        if (n == 7) begin
          vec_test.push_back(t);
          vec_op.push_back(op);
          vec_mask.push_back(m);
          vec_reg.push_back(a);
          vec_d0.push_back(x0);
          vec_d1.push_back(x1);
          vec_d2.push_back(x2);
        end
      end
      $fclose(fd);
    end
    vec_cnt = vec_test.size();
    if (vec_cnt == 0) begin
      $display("No vectors were loaded");
      tb_err++;
    end
  endtask

  // Access on every port in the mask, each port released on its own ready
  task automatic bus_access(input logic [1:0] mask, input logic wr, input logic [3:0] addr,
                            input logic [31:0] d0, input logic [31:0] d1);
    logic [`DMA_NUM_PORTS-1:0] open, acked;
    @(negedge clk);
    for (int p = 0; p < `DMA_NUM_PORTS; p++) begin
      if (mask[p]) begin
        reg_valid[p]   = 1'b1;
        reg_write[p]   = wr;
        reg_addr[p]    = addr;
        reg_wdata[p]   = (p == 0) ? d0 : d1;
        exp_rd_en[p]   = !wr;
        exp_rd_data[p] = (p == 0) ? d0 : d1;
      end
    end
    open = mask;
    while (open != '0) begin
      @(posedge clk);
      acked = open & reg_ready;
      @(negedge clk);
      for (int p = 0; p < `DMA_NUM_PORTS; p++) begin
        if (acked[p]) begin
          reg_valid[p] = 1'b0;
          exp_rd_en[p] = 1'b0;
        end
      end
      open = open & ~acked;
    end
  endtask

  // Waits for owed bursts, and for done pulses unless they are held back
  task automatic settle();
    while (exp_pending || (!hold_done && taken_cnt != done_cnt)) begin
      @(posedge clk);
    end
    repeat (2) @(posedge clk);
  endtask

  task automatic finish_test();
    while (exp_pending) begin
      @(posedge clk);
    end
    @(negedge clk);
    test_end = 1'b1;
    @(negedge clk);
    test_end = 1'b0;
  endtask

  task automatic run_vector(input int i);
    case (vec_op[i])
      "W": bus_access(2'(vec_mask[i]), 1'b1, 4'(vec_reg[i]), vec_d0[i][31:0], vec_d1[i][31:0]);
      "R": bus_access(2'(vec_mask[i]), 1'b0, 4'(vec_reg[i]), vec_d0[i][31:0], vec_d1[i][31:0]);
      "B": begin
        @(negedge clk);
        exp_burst.src_addr = vec_d0[i];
        exp_burst.dst_addr = vec_d1[i];
        exp_burst.length   = vec_d2[i][31:0];
        exp_push = 1'b1;
        @(negedge clk);
        exp_push = 1'b0;
      end
      "H": begin
        @(posedge clk);
        hold_done = vec_d0[i][0];
      end
      "S": settle();
      default: begin
        $display("Unknown vector operation on vector %0d", i);
        tb_err++;
      end
    endcase
  endtask

  initial begin : stimulus
    int unsigned afail;
    rst_n       = 1'b0;
    reg_valid   = '0;
    reg_write   = '0;
    reg_addr    = '0;
    reg_wdata   = '0;
    exp_rd_en   = '0;
    exp_rd_data = '0;
    exp_burst   = '0;
    exp_push    = 1'b0;
    test_end    = 1'b0;
    hold_done   = 1'b0;
    cur_test    = 0;
    load_vectors();
    loaded = 1'b1;
    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    if (vec_cnt > 0) begin
      cur_test = vec_test[0];
    end
    for (int i = 0; i < vec_cnt; i++) begin
      if (vec_test[i] != cur_test) begin
        finish_test();
        cur_test = vec_test[i];
      end
      run_vector(i);
    end
    finish_test();
    repeat (2) @(posedge clk);
    afail = dma_2d_top_i.dma_2d_midend_i.dma_sva_chk_i.fail_cnt;
    $display("Checks %0d, mismatches %0d, assertion failures %0d, testbench errors %0d",
             chk_cnt, err_cnt, afail, tb_err);
    if (err_cnt == 0 && afail == 0 && tb_err == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  // Budget of 200 cycles per vector plus reset
  initial begin : watchdog
    wait (loaded);
    #((vec_cnt * 200 + 32) * 2 * CLK_HALF);
    $display("Watchdog expired after %0d cycles", vec_cnt * 200 + 32);
    $display("** FAIL **");
    $finish;
  end

endmodule

/* test/dma_vectors.txt */
# test op port_mask reg data_port0 data_port1 extra, all but test in hex
# W write, R read and compare, B burst src dst length, H hold done (data_port0), S settle
1 W 1 0 11110000 0 0
1 W 2 0 0 22220000 0
1 R 3 0 11110000 22220000 0
1 W 1 5 ffffffff 0 0
1 R 3 5 1 0 0
1 W 3 a dead beef 0
1 W 3 b 3 3 0
1 R 3 a 0 0 0
1 R 3 b 0 0 0
2 W 1 0 1000 0 0
2 W 1 1 1 0 0
2 W 1 2 2000 0 0
2 W 1 3 2 0 0
2 W 1 4 40 0 0
2 W 1 5 0 0 0
2 W 1 6 100 0 0
2 W 1 8 5 0 0
2 B 0 0 100001000 200002000 40
2 R 1 9 1 0 0
2 S 0 0 0 0 0
2 R 1 a 1 0 0
3 W 2 0 0 3000 0
3 W 2 2 0 8000 0
3 W 2 4 0 20 0
3 W 2 6 0 100 0
3 W 2 7 0 200 0
3 W 2 8 0 3 0
3 W 2 5 0 1 0
3 B 0 0 3000 8000 20
3 B 0 0 3100 8200 20
3 B 0 0 3200 8400 20
3 R 2 9 0 2 0
3 S 0 0 0 0 0
4 H 0 0 1 0 0
4 B 0 0 100001000 200002000 40
4 B 0 0 3000 8000 20
4 B 0 0 3100 8200 20
4 B 0 0 3200 8400 20
4 R 3 9 3 4 0
4 S 0 0 0 0 0
5 R 3 b 2 2 0
5 R 3 a 2 2 0
5 H 0 0 0 0 0
5 S 0 0 0 0 0
5 R 3 a 4 4 0
5 R 3 b 0 0 0

/* sim.f */
+incdir+common
common/dma_reg_pkg.sv
common/dma_req_pkg.sv
frontend/dma_reg_file.sv
frontend/dma_rr_arb.sv
frontend/dma_reg_frontend.sv
midend/dma_2d_midend.sv
hw/dma_2d_top.sv
test/dma_sva_chk.sv
test/dma_monitor.sv
test/dma_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the DMA testbench with Verilator, run it and scan the log
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
  -f sim.f --top-module dma_tb -o dma_sim
./obj_dir/dma_sim +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log
if grep -qx '\*\* PASS \*\*' sim.log; then
  exit 0
fi
exit 1
